/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sat_bin_ctrl
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
src/sat_bin_pkg.sv
src/flag_change_detect.sv
src/analyze_ctrl.sv
src/learnt_slot_select.sv
src/backtrack_select.sv
src/var_state_chain.sv
src/sat_bin_ctrl.sv
tb/tb_sat_bin_ctrl.sv

/* src/analyze_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module analyze_ctrl
	import sat_bin_pkg::*;
(
	input  wire  clk,
	input  wire  rst,
	input  wire  apply_analyze_i,
	input  wire  conflict_chg_i,
	input  wire  local_bkt_i,
	output logic capture_o,
	output logic apply_backtrack_o,
	output logic done_analyze_o
);

	analyze_state_e state;
	analyze_state_e state_nxt;

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= AN_IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			AN_IDLE:
				if (apply_analyze_i)
					state_nxt = AN_FIND_CONFLICT;
			// wait for the cells to report a conflict
			AN_FIND_CONFLICT:
				if (conflict_chg_i)
					state_nxt = AN_ADD_LEARNT;
			AN_ADD_LEARNT:
				if (local_bkt_i)
					state_nxt = AN_BACKTRACK;
				else
					state_nxt = AN_DONE;
			AN_BACKTRACK:
				state_nxt = AN_DONE;
			AN_DONE:
				state_nxt = AN_IDLE;
			default:
				state_nxt = AN_IDLE;
		endcase
	end

	// slot and level capture strobe
	assign capture_o = (state == AN_ADD_LEARNT);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			apply_backtrack_o <= 1'b0;
			done_analyze_o    <= 1'b0;
		end
		else
		begin
			apply_backtrack_o <= (state == AN_BACKTRACK);
			done_analyze_o    <= (state == AN_DONE);
		end
	end

	// every capture leads to one of the two pulses
	a_learnt_exit: assert property (@(posedge clk) disable iff (rst)
		capture_o |-> ##2 (apply_backtrack_o || done_analyze_o));

	a_pulse_excl: assert property (@(posedge clk) disable iff (rst)
		apply_backtrack_o |-> !done_analyze_o ##1 done_analyze_o);

endmodule

`default_nettype wire

/* src/backtrack_select.sv */
`timescale 1ns/10ps
`default_nettype none

module backtrack_select
	import sat_bin_pkg::*;
(
	input  wire                clk,
	input  wire                rst,
	input  wire                capture_i,
	input  wire level_t        var_level_i [NUM_VARS],
	input  wire bin_t          var_bin_i [NUM_VARS],
	input  wire [NUM_VARS-1:0] exist_var_not_vbkt_i,
	input  wire bin_t          cur_bin_num_i,
	output logic               local_bkt_o,
	output logic               exist_var_not_vbkt_o,
	output level_t             bkt_lvl_o,
	output bin_t               bkt_bin_num_o
);

	level_t max_lvl;
	bin_t   bin_or;

	always_comb
	begin
		max_lvl = '0;
		bin_or  = '0;
		for (int i = 0; i < NUM_VARS; i++)
		begin
			if (var_level_i[i] > max_lvl)
				max_lvl = var_level_i[i];
			bin_or = bin_or | var_bin_i[i];
		end
	end

	assign exist_var_not_vbkt_o = |exist_var_not_vbkt_i;

	// backtrack stays inside this bin only if every var agrees
	assign local_bkt_o = (bin_or == cur_bin_num_i) && !exist_var_not_vbkt_o;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bkt_lvl_o     <= '0;
			bkt_bin_num_o <= '0;
		end
		else if (capture_i)
		begin
			bkt_lvl_o     <= max_lvl;
			bkt_bin_num_o <= bin_or;
		end
	end

endmodule

`default_nettype wire

/* src/flag_change_detect.sv */
`timescale 1ns/10ps
`default_nettype none

module flag_change_detect
	import sat_bin_pkg::*;
(
	input  wire                clk,
	input  wire                rst,
	input  wire                apply_implication_i,
	input  wire [NUM_VARS-1:0] find_imply_i,
	input  wire [NUM_VARS-1:0] find_conflict_i,
	output logic               done_imply_o,
	output logic               conflict_chg_o
);

	logic [NUM_VARS-1:0] imply_pre;
	logic [NUM_VARS-1:0] conflict_pre;
	logic                imply_chg;

	// flag vectors as seen one cycle earlier
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			imply_pre    <= '0;
			conflict_pre <= '0;
		end
		else
		begin
			imply_pre    <= find_imply_i;
			conflict_pre <= find_conflict_i;
		end
	end

	assign imply_chg      = (find_imply_i != imply_pre);
	assign conflict_chg_o = (find_conflict_i != conflict_pre);

	always_ff @(posedge clk)
	begin
		if (rst)
			done_imply_o <= 1'b0;
		else
			done_imply_o <= apply_implication_i && imply_chg;
	end

	// back-to-back pulses need a fresh change of the imply flags
	a_imply_single: assert property (@(posedge clk) disable iff (rst)
		(done_imply_o && $past(done_imply_o))
			|-> ($past(find_imply_i) != $past(find_imply_i, 2)));

endmodule

`default_nettype wire

/* src/learnt_slot_select.sv */
`timescale 1ns/10ps
`default_nettype none

module learnt_slot_select
	import sat_bin_pkg::*;
(
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 capture_i,
	input  wire len_t           clause_len_i [NUM_SLOTS],
	output logic [NUM_SLOTS-1:0] insert_ptr_o
);

	len_t max_l1 [NUM_SLOTS/2];
	len_t max_l2 [NUM_SLOTS/4];
	len_t max_len;
	logic len_over_max;

	// pairwise maximum tree 12 -> 6 -> 3 -> 1
	always_comb
	begin
		for (int i = 0; i < NUM_SLOTS/2; i++)
			max_l1[i] = (clause_len_i[2*i] > clause_len_i[2*i+1]) ?
				clause_len_i[2*i] : clause_len_i[2*i+1];
		for (int i = 0; i < NUM_SLOTS/4; i++)
			max_l2[i] = (max_l1[2*i] > max_l1[2*i+1]) ? max_l1[2*i] : max_l1[2*i+1];
		max_len = max_l2[0];
		for (int i = 1; i < NUM_SLOTS/4; i++)
			if (max_l2[i] > max_len)
				max_len = max_l2[i];
		len_over_max = 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++)
			if (clause_len_i[i] > max_len)
				len_over_max = 1'b1;
	end

	// every slot holding the longest clause
	always_ff @(posedge clk)
	begin
		if (rst)
			insert_ptr_o <= '0;
		else if (capture_i)
		begin
			for (int i = 0; i < NUM_SLOTS; i++)
				insert_ptr_o[i] <= (clause_len_i[i] == max_len);
		end
		else
			insert_ptr_o <= '0;
	end

	// the tree must not miss any slot
	a_ptr_after_capture: assert property (@(posedge clk) disable iff (rst)
		capture_i |-> !len_over_max);

endmodule

`default_nettype wire

/* src/sat_bin_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module sat_bin_ctrl
	import sat_bin_pkg::*;
(
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          apply_implication_i,
	input  wire                          apply_analyze_i,
	input  wire                          set_vars_states_i,
	input  wire                          get_vars_states_i,
	input  wire [NUM_VARS-1:0]           find_imply_i,
	input  wire [NUM_VARS-1:0]           find_conflict_i,
	input  wire [NUM_VARS-1:0]           exist_var_not_vbkt_i,
	input  wire [NUM_VARS*LEVEL_W-1:0]   var_level_i,
	input  wire [NUM_VARS*BIN_W-1:0]     var_bin_i,
	input  wire bin_t                    cur_bin_num_i,
	input  wire [NUM_SLOTS*LEN_W-1:0]    clause_len_i,
	input  wire var_state_t              vars_states_i,
	output logic                         done_imply_o,
	output logic                         done_analyze_o,
	output logic                         apply_backtrack_o,
	output logic                         exist_var_not_vbkt_o,
	output logic [NUM_SLOTS-1:0]         insert_ptr_o,
	output level_t                       bkt_lvl_o,
	output bin_t                         bkt_bin_num_o,
	output var_state_t                   vars_states_o
);

	level_t var_level [NUM_VARS];
	bin_t   var_bin [NUM_VARS];
	len_t   clause_len [NUM_SLOTS];
	logic   conflict_chg;
	logic   capture;
	logic   local_bkt;

	// element k sits at the k-th slice from the lsb
	for (genvar k = 0; k < NUM_VARS; k++)
	begin : g_var
		assign var_level[k] = var_level_i[k*LEVEL_W +: LEVEL_W];
		assign var_bin[k]   = var_bin_i[k*BIN_W +: BIN_W];
	end

	for (genvar k = 0; k < NUM_SLOTS; k++)
	begin : g_slot
		assign clause_len[k] = clause_len_i[k*LEN_W +: LEN_W];
	end

	flag_change_detect u_flag_change_detect (
		.clk                 (clk),
		.rst                 (rst),
		.apply_implication_i (apply_implication_i),
		.find_imply_i        (find_imply_i),
		.find_conflict_i     (find_conflict_i),
		.done_imply_o        (done_imply_o),
		.conflict_chg_o      (conflict_chg)
	);

	analyze_ctrl u_analyze_ctrl (
		.clk               (clk),
		.rst               (rst),
		.apply_analyze_i   (apply_analyze_i),
		.conflict_chg_i    (conflict_chg),
		.local_bkt_i       (local_bkt),
		.capture_o         (capture),
		.apply_backtrack_o (apply_backtrack_o),
		.done_analyze_o    (done_analyze_o)
	);

	learnt_slot_select u_learnt_slot_select (
		.clk          (clk),
		.rst          (rst),
		.capture_i    (capture),
		.clause_len_i (clause_len),
		.insert_ptr_o (insert_ptr_o)
	);

	backtrack_select u_backtrack_select (
		.clk                  (clk),
		.rst                  (rst),
		.capture_i            (capture),
		.var_level_i          (var_level),
		.var_bin_i            (var_bin),
		.exist_var_not_vbkt_i (exist_var_not_vbkt_i),
		.cur_bin_num_i        (cur_bin_num_i),
		.local_bkt_o          (local_bkt),
		.exist_var_not_vbkt_o (exist_var_not_vbkt_o),
		.bkt_lvl_o            (bkt_lvl_o),
		.bkt_bin_num_o        (bkt_bin_num_o)
	);

	var_state_chain u_var_state_chain (
		.clk               (clk),
		.rst               (rst),
		.set_vars_states_i (set_vars_states_i),
		.get_vars_states_i (get_vars_states_i),
		.vars_states_i     (vars_states_i),
		.vars_states_o     (vars_states_o)
	);

endmodule

`default_nettype wire

/* src/sat_bin_pkg.sv */
`default_nettype none

package sat_bin_pkg;

	// bin geometry
	localparam int NUM_VARS  = 24;
	localparam int NUM_SLOTS = 12;

	// field widths
	localparam int LEVEL_W = 15;
	localparam int LEN_W   = 10;
	localparam int BIN_W   = 10;
	localparam int STATE_W = 30;

	typedef logic [LEVEL_W-1:0] level_t;
	typedef logic [LEN_W-1:0]   len_t;
	typedef logic [BIN_W-1:0]   bin_t;
	typedef logic [STATE_W-1:0] var_state_t;

	// conflict analysis sequence
	typedef enum logic [2:0] {
		AN_IDLE          = 3'd0,
		AN_FIND_CONFLICT = 3'd1,
		AN_ADD_LEARNT    = 3'd2,
		AN_BACKTRACK     = 3'd3,
		AN_DONE          = 3'd4
	} analyze_state_e;

endpackage

`default_nettype wire

/* src/var_state_chain.sv */
`timescale 1ns/10ps
`default_nettype none

module var_state_chain
	import sat_bin_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire             set_vars_states_i,
	input  wire             get_vars_states_i,
	input  wire var_state_t vars_states_i,
	output var_state_t      vars_states_o
);

	var_state_t stage [NUM_VARS];
	logic       shift;

	// save and restore both move the chain one step
	assign shift = set_vars_states_i || get_vars_states_i;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_VARS; i++)
				stage[i] <= '0;
		end
		else if (shift)
		begin
			for (int i = 0; i < NUM_VARS-1; i++)
				stage[i] <= stage[i+1];
			stage[NUM_VARS-1] <= vars_states_i;
		end
	end

	assign vars_states_o = stage[0];

endmodule

`default_nettype wire

/* tb/tb_sat_bin_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sat_bin_ctrl
	import sat_bin_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int NUM_RUNS   = 12;
	// reset and idle, implication, analysis runs, chain fill and drain, margin
	localparam int RUN_CYCLES = 10 + 20 + NUM_RUNS * 40 + 2 * NUM_VARS * 4 + 100;

	logic                        clk;
	logic                        rst;
	logic                        apply_implication_i;
	logic                        apply_analyze_i;
	logic                        set_vars_states_i;
	logic                        get_vars_states_i;
	logic [NUM_VARS-1:0]         find_imply_i;
	logic [NUM_VARS-1:0]         find_conflict_i;
	logic [NUM_VARS-1:0]         exist_var_not_vbkt_i;
	logic [NUM_VARS*LEVEL_W-1:0] var_level_i;
	logic [NUM_VARS*BIN_W-1:0]   var_bin_i;
	bin_t                        cur_bin_num_i;
	logic [NUM_SLOTS*LEN_W-1:0]  clause_len_i;
	var_state_t                  vars_states_i;
	logic                        done_imply_o;
	logic                        done_analyze_o;
	logic                        apply_backtrack_o;
	logic                        exist_var_not_vbkt_o;
	logic [NUM_SLOTS-1:0]        insert_ptr_o;
	level_t                      bkt_lvl_o;
	bin_t                        bkt_bin_num_o;
	var_state_t                  vars_states_o;

	logic [31:0]          seed;
	logic [NUM_VARS-1:0]  imply_prev;
	logic [NUM_VARS-1:0]  conflict_prev;
	analyze_state_e       ref_state;
	logic                 exp_done_imply;
	logic                 exp_backtrack;
	logic                 exp_done_analyze;
	logic [NUM_SLOTS-1:0] exp_insert_ptr;
	level_t               exp_bkt_lvl;
	bin_t                 exp_bkt_bin;
	var_state_t           ref_chain [NUM_VARS];
	var_state_t           saved_words [$];

	sat_bin_ctrl u_sat_bin_ctrl (.*);

	always #(CLK_PERIOD/2) clk = ~clk;

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 15);
	endfunction

	function automatic level_t max_level();
		level_t m;
		m = '0;
		for (int i = 0; i < NUM_VARS; i++)
			if (var_level_i[i*LEVEL_W +: LEVEL_W] > m)
				m = var_level_i[i*LEVEL_W +: LEVEL_W];
		return m;
	endfunction

	function automatic bin_t bin_union();
		bin_t u;
		u = '0;
		for (int i = 0; i < NUM_VARS; i++)
			u = u | var_bin_i[i*BIN_W +: BIN_W];
		return u;
	endfunction

	function automatic logic [NUM_SLOTS-1:0] longest_slots();
		len_t                 longest;
		logic [NUM_SLOTS-1:0] hits;
		longest = '0;
		for (int i = 0; i < NUM_SLOTS; i++)
			if (clause_len_i[i*LEN_W +: LEN_W] > longest)
				longest = clause_len_i[i*LEN_W +: LEN_W];
		for (int i = 0; i < NUM_SLOTS; i++)
			hits[i] = (clause_len_i[i*LEN_W +: LEN_W] == longest);
		return hits;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("[ERROR] %s is 0x%0h, expected 0x%0h", name, got, want);
		$display("Some tests failed");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("[ERROR] %s", what);
		$display("Some tests failed");
		$fatal(1, "%s", what);
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// reference model of the expected outputs
	always @(posedge clk)
	begin
		if (rst)
		begin
			imply_prev       <= '0;
			conflict_prev    <= '0;
			ref_state        <= AN_IDLE;
			exp_done_imply   <= 1'b0;
			exp_backtrack    <= 1'b0;
			exp_done_analyze <= 1'b0;
			exp_insert_ptr   <= '0;
			exp_bkt_lvl      <= '0;
			exp_bkt_bin      <= '0;
			for (int i = 0; i < NUM_VARS; i++)
				ref_chain[i] <= '0;
		end
		else
		begin
			imply_prev       <= find_imply_i;
			conflict_prev    <= find_conflict_i;
			exp_done_imply   <= apply_implication_i && (find_imply_i != imply_prev);
			exp_backtrack    <= (ref_state == AN_BACKTRACK);
			exp_done_analyze <= (ref_state == AN_DONE);
			exp_insert_ptr   <= '0;
			case (ref_state)
				AN_IDLE:
					if (apply_analyze_i)
						ref_state <= AN_FIND_CONFLICT;
				AN_FIND_CONFLICT:
					if (find_conflict_i != conflict_prev)
						ref_state <= AN_ADD_LEARNT;
				AN_ADD_LEARNT:
				begin
					exp_insert_ptr <= longest_slots();
					exp_bkt_lvl    <= max_level();
					exp_bkt_bin    <= bin_union();
					if (bin_union() == cur_bin_num_i && exist_var_not_vbkt_i == '0)
						ref_state <= AN_BACKTRACK;
					else
						ref_state <= AN_DONE;
				end
				AN_BACKTRACK:
					ref_state <= AN_DONE;
				// AN_DONE goes back to idle
				default:
					ref_state <= AN_IDLE;
			endcase
			if (set_vars_states_i || get_vars_states_i)
			begin
				for (int i = 0; i < NUM_VARS-1; i++)
					ref_chain[i] <= ref_chain[i+1];
				ref_chain[NUM_VARS-1] <= vars_states_i;
			end
		end
	end

	a_done_imply: assert property (@(posedge clk) disable iff (rst)
		done_imply_o == exp_done_imply)
		else report_mismatch("done_imply_o", 64'($sampled(done_imply_o)),
			64'($sampled(exp_done_imply)));
	a_backtrack: assert property (@(posedge clk) disable iff (rst)
		apply_backtrack_o == exp_backtrack)
		else report_mismatch("apply_backtrack_o", 64'($sampled(apply_backtrack_o)),
			64'($sampled(exp_backtrack)));
	a_done_analyze: assert property (@(posedge clk) disable iff (rst)
		done_analyze_o == exp_done_analyze)
		else report_mismatch("done_analyze_o", 64'($sampled(done_analyze_o)),
			64'($sampled(exp_done_analyze)));
	a_exist: assert property (@(posedge clk) disable iff (rst)
		exist_var_not_vbkt_o == (|exist_var_not_vbkt_i))
		else report_mismatch("exist_var_not_vbkt_o", 64'($sampled(exist_var_not_vbkt_o)),
			64'(|$sampled(exist_var_not_vbkt_i)));
	a_insert_ptr: assert property (@(posedge clk) disable iff (rst)
		insert_ptr_o == exp_insert_ptr)
		else report_mismatch("insert_ptr_o", 64'($sampled(insert_ptr_o)),
			64'($sampled(exp_insert_ptr)));
	a_bkt_lvl: assert property (@(posedge clk) disable iff (rst)
		bkt_lvl_o == exp_bkt_lvl)
		else report_mismatch("bkt_lvl_o", 64'($sampled(bkt_lvl_o)),
			64'($sampled(exp_bkt_lvl)));
	a_bkt_bin: assert property (@(posedge clk) disable iff (rst)
		bkt_bin_num_o == exp_bkt_bin)
		else report_mismatch("bkt_bin_num_o", 64'($sampled(bkt_bin_num_o)),
			64'($sampled(exp_bkt_bin)));
	a_chain: assert property (@(posedge clk) disable iff (rst)
		vars_states_o == ref_chain[0])
		else report_mismatch("vars_states_o", 64'($sampled(vars_states_o)),
			64'($sampled(ref_chain[0])));

	task automatic check_implication();
		apply_implication_i = 1'b1;
		repeat (6)
		begin
			find_imply_i = find_imply_i ^ NUM_VARS'(next_random());
			step();
		end
		// constant flags under apply
		repeat (4) step();
		apply_implication_i = 1'b0;
		repeat (4)
		begin
			find_imply_i = ~find_imply_i;
			step();
		end
	endtask

	// mode 0 local, 1 foreign bin bit, 2 var not backtracked
	task automatic run_analysis(input int mode, input bit tie);
		bin_t cur;
		len_t top;
		int   a;
		int   gap;
		int   cycles;
		int   bkt_cycle;
		cur = bin_t'(next_random()) & 10'h1ff;
		cur_bin_num_i = cur;
		exist_var_not_vbkt_i = '0;
		for (int i = 0; i < NUM_VARS; i++)
		begin
			var_level_i[i*LEVEL_W +: LEVEL_W] = level_t'(next_random());
			var_bin_i[i*BIN_W +: BIN_W] = cur & bin_t'(next_random());
		end
		var_bin_i[(NUM_VARS-1)*BIN_W +: BIN_W] = cur;
		a = int'(next_random() % 32'd24);
		if (mode == 1)
			var_bin_i[0 +: BIN_W] = ~cur;
		else if (mode == 2)
			exist_var_not_vbkt_i[a] = 1'b1;
		for (int i = 0; i < NUM_SLOTS; i++)
			clause_len_i[i*LEN_W +: LEN_W] = len_t'(next_random()) & 10'h1ff;
		if (tie)
		begin
			top = 10'h200 | (len_t'(next_random()) & 10'h0ff);
			a = int'(next_random() % 32'd12);
			clause_len_i[a*LEN_W +: LEN_W] = top;
			clause_len_i[((a + 5) % NUM_SLOTS)*LEN_W +: LEN_W] = top;
		end
		gap = int'(next_random() % 32'd10);
		apply_analyze_i = 1'b1;
		step();
		apply_analyze_i = 1'b0;
		repeat (gap) step();
		find_conflict_i = find_conflict_i ^ (NUM_VARS'(1) << (next_random() % 32'd24));
		cycles = 0;
		bkt_cycle = -1;
		while (done_analyze_o !== 1'b1)
		begin
			if (apply_backtrack_o === 1'b1)
				bkt_cycle = cycles;
			step();
			cycles++;
			if (cycles > 20)
				report_failure("done_analyze_o never pulsed after the conflict flags changed");
		end
		if (mode == 0)
			assert (bkt_cycle == cycles - 1)
			else report_failure("apply_backtrack_o did not pulse just before done_analyze_o");
		else
			assert (bkt_cycle < 0)
			else report_failure("apply_backtrack_o pulsed for a non-local backtrack");
		repeat (2) step();
	endtask

	task automatic check_state_chain();
		var_state_t  word;
		logic [31:0] pick;
		for (int i = 0; i < 2 * NUM_VARS; i++)
		begin
			if (i >= NUM_VARS)
			begin
				word = saved_words.pop_front();
				assert (vars_states_o == word)
				else report_mismatch("vars_states_o", 64'(vars_states_o), 64'(word));
			end
			word = var_state_t'(next_random());
			if (i < NUM_VARS)
				saved_words.push_back(word);
			vars_states_i = word;
			pick = next_random();
			set_vars_states_i = pick[0];
			get_vars_states_i = !pick[0] || pick[1];
			step();
			set_vars_states_i = 1'b0;
			get_vars_states_i = 1'b0;
			repeat (int'(pick[5:4] % 2'd3)) step();
		end
	endtask

	initial
	begin
		seed = 32'h4ad8;
		clk = 1'b0;
		rst = 1'b1;
		apply_implication_i = 1'b0;
		apply_analyze_i = 1'b0;
		set_vars_states_i = 1'b0;
		get_vars_states_i = 1'b0;
		find_imply_i = '0;
		find_conflict_i = '0;
		exist_var_not_vbkt_i = '0;
		var_level_i = '0;
		var_bin_i = '0;
		cur_bin_num_i = '0;
		clause_len_i = '0;
		vars_states_i = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		// idle outputs after reset
		repeat (5) step();
		check_implication();
		for (int r = 0; r < NUM_RUNS; r++)
			run_analysis(r % 3, r % 2 == 1);
		check_state_chain();
		repeat (3) step();
		$display("All tests passed");
		$finish;
	end

	initial
	begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("[ERROR] the run timed out after %0d cycles", RUN_CYCLES);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
